// ==== verilog.f ====
+incdir+bench
common/fir_pkg.sv
common/axil_pkg.sv
src/axil_regs.sv
src/coef_ram.sv
fir_core/tap_counter.sv
fir_core/sample_buffer.sv
fir_core/mac_unit.sv
fir_core/fir_ctrl.sv
src/fir_top.sv
bench/fir_tb.sv

// ==== Bender.yml ====
package:
  name: fir_axis

sources:
  - common/fir_pkg.sv
  - common/axil_pkg.sv
  - src/axil_regs.sv
  - src/coef_ram.sv
  - fir_core/tap_counter.sv
  - fir_core/sample_buffer.sv
  - fir_core/mac_unit.sv
  - fir_core/fir_ctrl.sv
  - src/fir_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/fir_tb.sv

// ==== bench/fir_tb_tasks.svh ====
// fir_tb_tasks: random source, AXI-Lite bus tasks and typed result checks for the FIR testbench
`ifndef FIR_TB_TASKS_SVH
`define FIR_TB_TASKS_SVH

// 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit returned
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  logic        fb;
  val = '0;
  for (int i = 0; i < n; i++) begin
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    val    = {val[30:0], fb};
  end
  return val;
endfunction

// single handshake level against its expected state
task automatic check_flag(input logic got, input logic want, input string what);
  if (got !== want) begin
    $display("ERROR at time %0t: %s, got %b, expected %b", $time, what, got, want);
    $display("TESTBENCH FAILED");
    $fatal(1, "handshake mismatch");
  end
endtask

// address and data together, done once awready shows up
task automatic axil_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
  awaddr  = addr;
  wdata   = data;
  awvalid = 1'b1;
  wvalid  = 1'b1;
  do begin
    @(posedge axis_clk);
    #1;
    check_flag(wready, awready, "wready pulse with awready");
  end while (!awready);
  awvalid = 1'b0;
  wvalid  = 1'b0;
endtask

task automatic axil_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
  check_flag(arready, 1'b1, "arready with no read pending");
  araddr  = addr;
  arvalid = 1'b1;
  rready  = 1'b1;
  do begin
    @(posedge axis_clk);
    #1;
  end while (!rvalid);
  check_flag(arready, 1'b0, "arready while read data pending");
  data    = rdata;
  arvalid = 1'b0;
  @(posedge axis_clk);  // read handshake edge
  #1;
  rready = 1'b0;
endtask

task automatic check_word(input logic [data_w-1:0] got, input logic [data_w-1:0] want,
                          input string what);
  if (got !== want) begin
    $display("ERROR at time %0t: %s, got %h, expected %h", $time, what, got, want);
    $display("TESTBENCH FAILED");
    $fatal(1, "word mismatch");
  end
endtask

task automatic check_status(input ap_status_t got, input ap_status_t want, input string what);
  if (got !== want) begin
    $display("ERROR at time %0t: %s, got start/done/idle %b/%b/%b, expected %b/%b/%b",
             $time, what, got.start, got.done, got.idle, want.start, want.done, want.idle);
    $display("TESTBENCH FAILED");
    $fatal(1, "status mismatch");
  end
endtask

task automatic check_beat(input axis_beat_t got, input axis_beat_t want, input string what);
  if (got !== want) begin
    $display("ERROR at time %0t: %s, got data %h last %b, expected data %h last %b",
             $time, what, got.data, got.last, want.data, want.last);
    $display("TESTBENCH FAILED");
    $fatal(1, "beat mismatch");
  end
endtask

`endif

// ==== bench/fir_tb.sv ====
// fir_tb: random stream test of the AXI FIR filter against a software FIR model
`default_nettype none

module fir_tb import fir_pkg::*, axil_pkg::*; ();

  localparam int max_taps       = 32;
  localparam int n_runs         = 2;
  localparam int data_len       = 40;
  localparam int coef_long      = 23;  // larger of the two tap counts
  localparam int timeout_cycles = 4 * (n_runs * data_len * (coef_long + 8) + 200);

  logic              axis_clk, axis_rst_n;
  logic              awvalid, awready, wvalid, wready;
  logic              arvalid, arready, rvalid, rready;
  logic [addr_w-1:0] awaddr, araddr;
  logic [data_w-1:0] wdata, rdata;
  logic              ss_tvalid, ss_tready, ss_tlast;
  logic              sm_tvalid, sm_tready, sm_tlast;
  logic [data_w-1:0] ss_tdata, sm_tdata;

  logic [31:0]       lfsr_q;
  logic [data_w-1:0] taps_m [max_taps];
  logic [data_w-1:0] hist_m [max_taps];   // model history, newest at 0
  logic [data_w-1:0] x_a [data_len];
  logic [data_w-1:0] y_a [data_len];
  int                gap_a [data_len];    // idle cycles before each input beat
  int                stall_a [data_len];  // cycles sm_tready stays low per output

  `include "fir_tb_tasks.svh"

  fir_top #(.max_taps(max_taps)) i_dut (.*);

  always #5 axis_clk = ~axis_clk;

  // reference FIR, truncated to data_w like the hardware
  function automatic logic [data_w-1:0] model_step(input logic [data_w-1:0] x, input int taps_used);
    logic [data_w-1:0] acc;
    for (int k = max_taps - 1; k > 0; k--) hist_m[k] = hist_m[k - 1];
    hist_m[0] = x;
    acc = '0;
    for (int k = 0; k < taps_used; k++) acc = acc + taps_m[k] * hist_m[k];
    return acc;
  endfunction

  task automatic feed_samples(input int n);
    logic hs;
    for (int i = 0; i < n; i++) begin
      repeat (gap_a[i]) begin
        @(posedge axis_clk);
        #1;
      end
      ss_tdata  = x_a[i];
      ss_tvalid = 1'b1;
      do begin
        hs = ss_tready;  // ready for the coming edge
        @(posedge axis_clk);
        #1;
      end while (!hs);
      ss_tvalid = 1'b0;
    end
  endtask

  task automatic take_outputs(input int n);
    axis_beat_t got, want;
    for (int i = 0; i < n; i++) begin
      while (!sm_tvalid) begin
        @(posedge axis_clk);
        #1;
      end
      want.data = y_a[i];
      want.last = (i == n - 1);
      got.data  = sm_tdata;
      got.last  = sm_tlast;
      check_beat(got, want, $sformatf("output beat %0d", i));
      repeat (stall_a[i]) begin  // beat must hold under back-pressure
        @(posedge axis_clk);
        #1;
      end
      check_flag(sm_tvalid, 1'b1, $sformatf("sm_tvalid held for beat %0d", i));
      got.data = sm_tdata;
      got.last = sm_tlast;
      check_beat(got, want, $sformatf("output beat %0d after stall", i));
      sm_tready = 1'b1;
      @(posedge axis_clk);
      #1;
      sm_tready = 1'b0;
    end
  endtask

  task automatic run_filter(input int taps_used);
    logic [data_w-1:0] word;
    axil_write(REG_DATA_LEN, data_len);
    axil_write(REG_COEF_LEN, taps_used);
    for (int k = 0; k < taps_used; k++) begin
      taps_m[k] = rand_bits(32);
      axil_write(addr_w'(REG_TAP_BASE + 4 * k), taps_m[k]);
    end
    axil_read(REG_DATA_LEN, word);
    check_word(word, data_len, "data_length readback");
    axil_read(REG_COEF_LEN, word);
    check_word(word, taps_used, "coef_length readback");
    for (int k = 0; k < taps_used; k++) begin
      axil_read(addr_w'(REG_TAP_BASE + 4 * k), word);
      check_word(word, taps_m[k], $sformatf("tap %0d readback", k));
    end

    for (int k = 0; k < max_taps; k++) hist_m[k] = '0;  // start clears the history
    for (int i = 0; i < data_len; i++) begin
      x_a[i]     = rand_bits(32);
      gap_a[i]   = rand_bits(2);
      stall_a[i] = rand_bits(2);
      y_a[i]     = model_step(x_a[i], taps_used);
    end

    axil_write(REG_AP_CTRL, 32'h1);
    axil_read(REG_TAP_BASE, word);
    check_word(word, 32'hffff_ffff, "tap read while busy");
    axil_read(REG_AP_CTRL, word);
    check_status(ap_status_t'(word[2:0]), ap_status_t'(3'b000), "ap_ctrl while busy");

    fork
      feed_samples(data_len);
      take_outputs(data_len);
    join

    axil_read(REG_AP_CTRL, word);
    check_status(ap_status_t'(word[2:0]), ap_status_t'(3'b010), "ap_ctrl after last beat");
    axil_read(REG_AP_CTRL, word);
    check_status(ap_status_t'(word[2:0]), ap_status_t'(3'b100), "ap_ctrl after done read");
  endtask

  initial begin
    logic [data_w-1:0] word;
    axis_clk   = 1'b0;
    axis_rst_n = 1'b0;
    {awvalid, wvalid, arvalid, rready} = '0;
    {ss_tvalid, ss_tlast, sm_tready}   = '0;
    awaddr     = '0;
    araddr     = '0;
    wdata      = '0;
    ss_tdata   = '0;
    lfsr_q     = 32'h48a2_cef1;
    repeat (2) @(posedge axis_clk);
    #1;
    axis_rst_n = 1'b1;

    axil_read(REG_AP_CTRL, word);
    check_status(ap_status_t'(word[2:0]), ap_status_t'(3'b100), "ap_ctrl after reset");
    run_filter(11);
    run_filter(coef_long);  // second run, fresh taps

    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin
    repeat (timeout_cycles) @(posedge axis_clk);
    $display("watchdog: run did not finish within %0d clock cycles", timeout_cycles);
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== src/fir_top.sv ====
// fir_top: FIR filter with AXI-Lite configuration and AXI-Stream sample path
`default_nettype none

module fir_top import fir_pkg::*, axil_pkg::*; #(
  parameter  int max_taps = 32,
  localparam int idx_w    = $clog2(max_taps)
) (
  input  logic              axis_clk,
  input  logic              axis_rst_n,
  input  logic              awvalid,
  output logic              awready,
  input  logic [addr_w-1:0] awaddr,
  input  logic              wvalid,
  output logic              wready,
  input  logic [data_w-1:0] wdata,
  input  logic              arvalid,
  output logic              arready,
  input  logic [addr_w-1:0] araddr,
  output logic              rvalid,
  input  logic              rready,
  output logic [data_w-1:0] rdata,
  input  logic              ss_tvalid,
  output logic              ss_tready,
  input  logic [data_w-1:0] ss_tdata,
  input  logic              ss_tlast,   // not used, run length comes from data_length
  output logic              sm_tvalid,
  input  logic              sm_tready,
  output logic [data_w-1:0] sm_tdata,
  output logic              sm_tlast
);

  axil_wr_t          coef_wr;
  axil_rd_t          coef_rd;
  ap_status_t        status;
  axis_beat_t        out_beat;
  logic              coef_we, ap_start, done_ack, busy;
  logic [data_w-1:0] data_length, coef_length, coef_q, tap_h, x_q;
  logic [idx_w-1:0]  tap_idx, cnt_max;
  logic              cnt_clr, cnt_en, cnt_last, buf_clear, buf_push;
  logic              mac_first, mac_en, out_load, out_last;

  assign sm_tdata = out_beat.data;
  assign sm_tlast = out_beat.last;

  axil_regs #(.max_taps(max_taps)) i_regs (.*);

  coef_ram #(.max_taps(max_taps)) i_coef_ram (.*);

  tap_counter #(.max_taps(max_taps)) i_tap_counter (.*);

  sample_buffer #(.max_taps(max_taps)) i_sample_buffer (.*);

  mac_unit i_mac (.*);

  fir_ctrl #(.max_taps(max_taps)) i_ctrl (.*);

endmodule

`default_nettype wire

// ==== fir_core/fir_ctrl.sv ====
// fir_ctrl: FSM sequencing history clear, sample intake, tap sweep and output
`default_nettype none

module fir_ctrl import fir_pkg::*; #(
  parameter  int max_taps = 32,
  localparam int idx_w    = $clog2(max_taps)
) (
  input  logic              axis_clk,
  input  logic              axis_rst_n,
  input  logic              ap_start,
  input  logic              done_ack,
  input  logic [data_w-1:0] data_length,
  input  logic [data_w-1:0] coef_length,
  input  logic              ss_tvalid,
  input  logic              sm_tready,
  input  logic              cnt_last,
  output ap_status_t        status,
  output logic              ss_tready,
  output logic              sm_tvalid,
  output logic              busy,
  output logic              cnt_clr,
  output logic              cnt_en,
  output logic [idx_w-1:0]  cnt_max,
  output logic              buf_clear,
  output logic              buf_push,
  output logic              mac_first,
  output logic              mac_en,
  output logic              out_load,
  output logic              out_last
);

  ap_state_e         state, state_nx;
  logic              flush_q;      // second flush cycle
  logic              start_q;
  logic [data_w-1:0] beat_cnt;     // output beats sent this run
  logic [data_w-1:0] coef_len_m1;
  logic [1:0]        en_pipe;      // tap enable through ram and multiply
  logic [2:0]        first_pipe;
  logic              accept;
  logic              out_hs;

  assign ss_tready = (state == AP_WAIT_IN);
  assign sm_tvalid = (state == AP_OUT);
  assign busy      = !(state == AP_IDLE || state == AP_DONE);
  assign accept    = ss_tvalid && ss_tready;
  assign out_hs    = sm_tvalid && sm_tready;
  assign out_last  = (beat_cnt == data_length - 1'b1);

  assign status.idle  = (state == AP_IDLE);
  assign status.done  = (state == AP_DONE);
  assign status.start = start_q;

  assign coef_len_m1 = coef_length - 1'b1;
  assign cnt_max     = (state == AP_CLEAR) ? idx_w'(max_taps - 1) : coef_len_m1[idx_w-1:0];
  assign cnt_clr     = (state == AP_IDLE && ap_start) || accept;
  assign cnt_en      = (state == AP_CLEAR) || (state == AP_TAPS);
  assign buf_clear   = (state == AP_CLEAR);
  assign buf_push    = accept;
  assign out_load    = (state == AP_FLUSH) && flush_q;
  assign mac_en      = en_pipe[1];
  assign mac_first   = first_pipe[2];

  always_comb begin
    state_nx = state;
    case (state)
      AP_IDLE:    if (ap_start) state_nx = AP_CLEAR;
      AP_CLEAR:   if (cnt_last) state_nx = AP_WAIT_IN;
      AP_WAIT_IN: if (accept) state_nx = AP_TAPS;
      AP_TAPS:    if (cnt_last) state_nx = AP_FLUSH;
      AP_FLUSH:   if (flush_q) state_nx = AP_OUT;
      AP_OUT:     if (out_hs) state_nx = out_last ? AP_DONE : AP_WAIT_IN;
      AP_DONE:    if (done_ack) state_nx = AP_IDLE;
      default:    state_nx = AP_IDLE;
    endcase
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state      <= AP_IDLE;
      flush_q    <= 1'b0;
      start_q    <= 1'b0;
      beat_cnt   <= '0;
      en_pipe    <= '0;
      first_pipe <= '0;
    end else begin
      state      <= state_nx;
      flush_q    <= (state == AP_FLUSH) && !flush_q;
      start_q    <= ap_start;  // self-clearing start bit
      en_pipe    <= {en_pipe[0], state == AP_TAPS};
      first_pipe <= {first_pipe[1:0], accept};  // accept edge marks tap 0
      if (ap_start) begin
        beat_cnt <= '0;
      end else if (out_hs) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  a_one_in_flight: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    !(ss_tready && sm_tvalid));

endmodule

`default_nettype wire

// ==== fir_core/mac_unit.sv ====
// mac_unit: two-stage multiply-accumulate feeding the output stream beat
`default_nettype none

module mac_unit import fir_pkg::*; (
  input  logic              axis_clk,
  input  logic              axis_rst_n,
  input  logic [data_w-1:0] x_q,
  input  logic [data_w-1:0] tap_h,
  input  logic              mac_first,
  input  logic              mac_en,
  input  logic              out_load,
  input  logic              out_last,
  output axis_beat_t        out_beat
);

  logic [data_w-1:0] prod_q;   // multiply stage
  logic [data_w-1:0] acc_q;
  logic [data_w-1:0] acc_nx;

  // products and sums kept to data_w bits
  assign acc_nx = (mac_first ? '0 : acc_q) + prod_q;

  always_ff @(posedge axis_clk) begin
    prod_q <= x_q * tap_h;
    if (mac_en) acc_q <= acc_nx;
  end

  // out_load lines up with the final accumulate, so take the sum directly
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      out_beat <= '0;
    end else if (out_load) begin
      out_beat.data <= acc_nx;
      out_beat.last <= out_last;
    end
  end

  a_beat_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    !out_load |=> $stable(out_beat));

endmodule

`default_nettype wire

// ==== fir_core/sample_buffer.sv ====
// sample_buffer: circular history of input samples, newest first on read
`default_nettype none

module sample_buffer import fir_pkg::*; #(
  parameter  int max_taps = 32,
  localparam int idx_w    = $clog2(max_taps)
) (
  input  logic              axis_clk,
  input  logic              axis_rst_n,
  input  logic              buf_clear,
  input  logic              buf_push,
  input  logic [idx_w-1:0]  tap_idx,
  input  logic [data_w-1:0] ss_tdata,
  output logic [data_w-1:0] x_q
);

  logic [data_w-1:0] mem [max_taps];
  logic [idx_w-1:0]  head_q;   // slot of the newest sample
  logic [idx_w-1:0]  wr_ptr;
  logic [idx_w-1:0]  rd_ptr;

  assign wr_ptr = head_q + 1'b1;
  assign rd_ptr = head_q - tap_idx;  // x[n-k], wraps modulo max_taps

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      head_q <= '0;
    end else if (buf_push) begin
      head_q <= wr_ptr;
    end
  end

  always_ff @(posedge axis_clk) begin
    if (buf_clear) begin
      mem[tap_idx] <= '0;  // clear pass walks every slot
    end else if (buf_push) begin
      mem[wr_ptr] <= ss_tdata;
    end
    x_q <= mem[rd_ptr];
  end

endmodule

`default_nettype wire

// ==== fir_core/tap_counter.sv ====
// tap_counter: index counter for the history clear pass and the tap sweep
`default_nettype none

module tap_counter #(
  parameter  int max_taps = 32,
  localparam int idx_w    = $clog2(max_taps)
) (
  input  logic             axis_clk,
  input  logic             axis_rst_n,
  input  logic             cnt_clr,
  input  logic             cnt_en,
  input  logic [idx_w-1:0] cnt_max,
  output logic [idx_w-1:0] tap_idx,
  output logic             cnt_last
);

  assign cnt_last = (tap_idx == cnt_max);

  // stops at cnt_max, no wrap
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      tap_idx <= '0;
    end else if (cnt_clr) begin
      tap_idx <= '0;
    end else if (cnt_en && !cnt_last) begin
      tap_idx <= tap_idx + 1'b1;
    end
  end

  // the limit comes from the controller and changes with its state
  a_idx_in_range: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    cnt_en |-> tap_idx <= cnt_max);

endmodule

`default_nettype wire

// ==== src/coef_ram.sv ====
// coef_ram: coefficient memory written by the host, read by host or filter
`default_nettype none

module coef_ram import fir_pkg::*, axil_pkg::*; #(
  parameter  int max_taps = 32,
  localparam int idx_w    = $clog2(max_taps)
) (
  input  logic              axis_clk,
  input  axil_wr_t          coef_wr,
  input  logic              coef_we,
  input  axil_rd_t          coef_rd,
  input  logic [idx_w-1:0]  tap_idx,
  input  logic              busy,
  output logic [data_w-1:0] coef_q,
  output logic [data_w-1:0] tap_h
);

  logic [data_w-1:0] mem [max_taps];
  logic [addr_w-1:0] wr_off;
  logic [addr_w-1:0] rd_off;

  // byte offset into the tap window
  assign wr_off = coef_wr.addr - REG_TAP_BASE;
  assign rd_off = coef_rd.addr - REG_TAP_BASE;

  always_ff @(posedge axis_clk) begin
    if (coef_we) mem[wr_off[idx_w+1:2]] <= coef_wr.data;
    tap_h <= mem[tap_idx];  // filter port
    // host sees all ones while the filter owns the ram
    coef_q <= busy ? '1 : mem[rd_off[idx_w+1:2]];
  end

endmodule

`default_nettype wire

// ==== src/axil_regs.sv ====
// axil_regs: AXI-Lite slave holding FIR configuration and reporting ap_ctrl status
`default_nettype none

module axil_regs import fir_pkg::*, axil_pkg::*; #(
  parameter int max_taps = 32
) (
  input  logic              axis_clk,
  input  logic              axis_rst_n,
  input  logic              awvalid,
  output logic              awready,
  input  logic [addr_w-1:0] awaddr,
  input  logic              wvalid,
  output logic              wready,
  input  logic [data_w-1:0] wdata,
  input  logic              arvalid,
  output logic              arready,
  input  logic [addr_w-1:0] araddr,
  output logic              rvalid,
  input  logic              rready,
  output logic [data_w-1:0] rdata,
  input  ap_status_t        status,
  input  logic [data_w-1:0] coef_q,
  output axil_wr_t          coef_wr,
  output logic              coef_we,
  output axil_rd_t          coef_rd,
  output logic [data_w-1:0] data_length,
  output logic [data_w-1:0] coef_length,
  output logic              ap_start,
  output logic              done_ack
);

  logic              wr_ack;     // awready/wready pulse
  logic              wr_go;
  logic              rd_go;
  logic [addr_w-1:0] rd_addr_q;
  logic              rd_tap_q;   // pending read targets the coefficient ram
  logic [data_w-1:0] rd_data_q;
  logic [data_w-1:0] reg_val;

  // address falls inside the tap window
  function automatic logic tap_hit(input logic [addr_w-1:0] a);
    logic [addr_w-1:0] off;
    off = a - REG_TAP_BASE;
    return (a >= REG_TAP_BASE) && (off < addr_w'(4 * max_taps));
  endfunction

  assign wr_go   = awvalid && wvalid && !wr_ack;
  assign awready = wr_ack;
  assign wready  = wr_ack;

  assign coef_wr  = {awaddr, wdata};
  assign coef_we  = wr_go && status.idle && tap_hit(awaddr);  // taps only change while idle
  assign ap_start = wr_go && status.idle && (awaddr == REG_AP_CTRL) && wdata[0];

  assign arready = !rvalid;
  assign rd_go   = arvalid && arready;
  assign coef_rd = rvalid ? rd_addr_q : araddr;  // hold address so coef_q stays put
  assign rdata   = rd_tap_q ? coef_q : rd_data_q;

  // ends AP_DONE in the controller
  assign done_ack = rvalid && rready && (rd_addr_q == REG_AP_CTRL);

  always_comb begin
    case (araddr)
      REG_AP_CTRL:  reg_val = data_w'(status);
      REG_DATA_LEN: reg_val = data_length;
      REG_COEF_LEN: reg_val = coef_length;
      default:      reg_val = '0;  // unmapped and tap addresses
    endcase
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      wr_ack      <= 1'b0;
      rvalid      <= 1'b0;
      data_length <= '0;
      coef_length <= '0;
    end else begin
      wr_ack <= wr_go;
      if (wr_go && (awaddr == REG_DATA_LEN)) data_length <= wdata;
      if (wr_go && (awaddr == REG_COEF_LEN)) coef_length <= wdata;
      if (rd_go) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // read snapshot taken when the address is accepted
  always_ff @(posedge axis_clk) begin
    if (rd_go) begin
      rd_addr_q <= araddr;
      rd_tap_q  <= tap_hit(araddr);
      rd_data_q <= reg_val;
    end
  end

  a_rvalid_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    rvalid && !rready |=> rvalid);

endmodule

`default_nettype wire

// ==== common/axil_pkg.sv ====
// axil_pkg: AXI-Lite request layout and FIR register map
`default_nettype none

package axil_pkg;

  parameter int addr_w = 12;

  // register offsets, tap k sits at REG_TAP_BASE + 4k
  typedef enum logic [addr_w-1:0] {
    REG_AP_CTRL  = 12'h000,
    REG_DATA_LEN = 12'h010,
    REG_COEF_LEN = 12'h014,
    REG_TAP_BASE = 12'h080
  } reg_addr_e;

  // accepted write, address plus data
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [31:0]       data;
  } axil_wr_t;

  // host read request
  typedef struct packed {
    logic [addr_w-1:0] addr;
  } axil_rd_t;

endpackage

`default_nettype wire

// ==== common/fir_pkg.sv ====
// fir_pkg: FIR datapath widths, controller states and stream beat layout
`default_nettype none

package fir_pkg;

  // sample, coefficient and result width
  parameter int data_w = 32;

  // controller sequence, one sample in flight at a time
  typedef enum logic [2:0] {
    AP_IDLE    = 3'd0,
    AP_CLEAR   = 3'd1,  // zero the sample history
    AP_WAIT_IN = 3'd2,  // ss_tready high
    AP_TAPS    = 3'd3,  // sweep coef_length taps
    AP_FLUSH   = 3'd4,  // drain ram read and multiply stages
    AP_OUT     = 3'd5,  // sm_tvalid high
    AP_DONE    = 3'd6
  } ap_state_e;

  // low three bits of ap_ctrl, bit 0 is start
  typedef struct packed {
    logic idle;
    logic done;
    logic start;
  } ap_status_t;

  // one AXI-Stream beat
  typedef struct packed {
    logic [data_w-1:0] data;
    logic              last;
  } axis_beat_t;

endpackage

`default_nettype wire
